// ==== src/spr_pkg.sv ====
// screen constants and record types for the sprite unit; objects are 8x8 only, 64 objects in OAM
package spr_pkg;

  ////////////////////////////////////////////////////////////
  // screen and buffer constants
  ////////////////////////////////////////////////////////////
  localparam int SPR_PER_LINE  = 8;    // line buffer depth, also number of output slots
  localparam int OAM_BYTES     = 256;  // 64 objects, 4 bytes each
  localparam int VISIBLE_LINES = 240;
  localparam int FETCH_START   = 256;  // pattern fetch begins here, evaluation ends here
  localparam int FETCH_END     = 320;  // line buffer count clears on this column
  localparam int COORD_W       = 10;

  typedef logic [COORD_W-1:0] coord_t;

  // screen position from the outside timing generator
  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t y_next;     // line being evaluated / fetched
    logic   pix_pulse;  // one clock just before x advances
  } scan_t;

  // one selected object, as kept in the line buffer
  typedef struct packed {
    logic       primary;  // oam entry 0
    logic [7:0] tile;
    logic [7:0] x;
    logic [1:0] palette;
    logic       prio;     // 1 puts the object behind the playfield
    logic       h_flip;
    logic [3:0] row;      // row inside the object, v flip already applied
  } line_entry_t;

  // fetched object ready for output, one per slot
  typedef struct packed {
    logic       primary;
    logic       prio;
    logic [1:0] palette;
    logic [7:0] plane1;
    logic [7:0] plane0;   // pixel 0 sits in bit 0
    logic [7:0] x;
  } slot_t;

  // final sprite pixel
  typedef struct packed {
    logic       primary;
    logic       prio;
    logic [3:0] index;    // palette bits, then plane 1, plane 0
  } pixel_t;

endpackage

// ==== src/spr_eval.sv ====
// OAM storage and per-line object evaluation; host writes land next edge, reads are combinational
`timescale 1ns/1ps

module spr_eval
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 en,
  input  spr_pkg::scan_t       scan,
  input  logic [7:0]           oam_addr,
  input  logic [7:0]           oam_wdata,
  input  logic                 oam_wr,
  input  logic                 full,        // from the line buffer
  output logic [7:0]           oam_rdata,
  output logic                 push,
  output spr_pkg::line_entry_t push_entry,
  output logic                 overflow     // 8 objects hit on some line this frame
);

  // byte 0 y minus one, byte 1 tile, byte 2 attributes, byte 3 x
  logic [7:0] oam_mem [spr_pkg::OAM_BYTES];

  logic [5:0]      obj_idx;
  logic [7:0]      obj_y;
  logic [7:0]      obj_tile;
  logic [7:0]      obj_attr;
  logic [7:0]      obj_x;
  spr_pkg::coord_t obj_top;
  spr_pkg::coord_t row_diff;
  logic            in_rng;
  logic            eval_slot;

  always_ff @(posedge clk_in)
  begin
    if (oam_wr)
      oam_mem[oam_addr] <= oam_wdata;
  end

  assign oam_rdata = oam_mem[oam_addr];

  ////////////////////////////////////////////////////////////
  // object decode, one object per 4 columns
  ////////////////////////////////////////////////////////////
  assign obj_idx  = scan.x[7:2];
  assign obj_y    = oam_mem[{obj_idx, 2'd0}];
  assign obj_tile = oam_mem[{obj_idx, 2'd1}];
  assign obj_attr = oam_mem[{obj_idx, 2'd2}];
  assign obj_x    = oam_mem[{obj_idx, 2'd3}];

  assign obj_top  = {2'b00, obj_y} + 10'd1;    // no wrap, y of 255 never shows
  assign row_diff = scan.y_next - obj_top;
  assign in_rng   = (row_diff < 10'd8);        // wraps high when above the object

  assign eval_slot = en && scan.pix_pulse
                     && (scan.y_next < spr_pkg::VISIBLE_LINES)
                     && (scan.x < spr_pkg::FETCH_START)
                     && (scan.x[1:0] == 2'd0);

  // objects past the eighth are simply skipped
  assign push = eval_slot && in_rng && !full;

  always_comb
  begin
    push_entry.primary = (obj_idx == 6'd0);
    push_entry.tile    = obj_tile;
    push_entry.x       = obj_x;
    push_entry.palette = obj_attr[1:0];
    push_entry.prio    = obj_attr[5];
    push_entry.h_flip  = obj_attr[6];
    // v flip mirrors the row within the 8 line object
    push_entry.row     = obj_attr[7] ? {1'b0, ~row_diff[2:0]} : row_diff[3:0];
  end

  // sticky for the frame, cleared at the frame start column
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      overflow <= 1'b0;
    else if ((scan.x == '0) && (scan.y_next == '0))
      overflow <= 1'b0;
    else if (full)
      overflow <= 1'b1;
  end

  // the buffer only fills through pushes from here
  a_full_after_push : assert property (
    @(posedge clk_in) disable iff (rst_in) $rose(full) |-> $past(push)
  ) else $error("line buffer filled without a push");

endmodule

// ==== src/spr_line_buf.sv ====
// holds up to 8 selected objects for the next line; count clears at the end-of-fetch pulse
`timescale 1ns/1ps

module spr_line_buf
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  spr_pkg::scan_t       scan,
  input  logic                 push,
  input  spr_pkg::line_entry_t push_entry,
  input  logic [2:0]           rd_idx,
  output logic                 full,
  output spr_pkg::line_entry_t rd_entry,
  output logic                 rd_valid
);

  spr_pkg::line_entry_t entry_mem [spr_pkg::SPR_PER_LINE];

  logic [3:0] count;     // 0 to 8 entries
  logic       line_end;

  assign line_end = scan.pix_pulse
                    && (scan.x == spr_pkg::FETCH_END)
                    && (scan.y_next < spr_pkg::VISIBLE_LINES);

  // entries are written at the current fill position
  always_ff @(posedge clk_in)
  begin
    if (push)
      entry_mem[count[2:0]] <= push_entry;
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      count <= '0;
    else if (line_end)
      count <= '0;          // fetch is done with this line
    else if (push)
      count <= count + 4'd1;
  end

  assign full     = (count == spr_pkg::SPR_PER_LINE);
  assign rd_entry = entry_mem[rd_idx];
  assign rd_valid = ({1'b0, rd_idx} < count);

  // relies on the evaluator honouring full
  a_count_bound : assert property (
    @(posedge clk_in) disable iff (rst_in) count <= spr_pkg::SPR_PER_LINE
  ) else $error("line buffer count above %0d", spr_pkg::SPR_PER_LINE);

endmodule

// ==== src/spr_fetch.sv ====
// pattern fetch for 8 slots, 8 columns each; vram data must arrive in the same clock as the address
`timescale 1ns/1ps

module spr_fetch
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 en,
  input  logic                 pt_sel,      // pattern table select
  input  spr_pkg::scan_t       scan,
  input  spr_pkg::line_entry_t rd_entry,
  input  logic                 rd_valid,
  input  logic [7:0]           vram_rdata,
  output logic [2:0]           rd_idx,
  output logic [13:0]          vram_addr,
  output logic                 vram_req,
  output logic                 slot_wr,
  output logic [2:0]           slot_idx,
  output spr_pkg::slot_t       slot_data
);

  logic       in_window;
  logic [1:0] sub_phase;    // 0 plane 0, 1 plane 1, 2 slot write
  logic [7:0] byte_ordered;
  logic [7:0] plane0_q;
  logic [7:0] plane1_q;

  function automatic logic [7:0] rev8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[i] = b[7 - i];
    return r;
  endfunction

  assign rd_idx    = scan.x[5:3];
  assign sub_phase = scan.x[2:1];
  assign in_window = en
                     && (scan.y_next < spr_pkg::VISIBLE_LINES)
                     && (scan.x >= spr_pkg::FETCH_START)
                     && (scan.x < spr_pkg::FETCH_END);

  // 32 bytes per tile, plane bit above the row
  assign vram_addr = {pt_sel, rd_entry.tile, scan.x[1], rd_entry.row};
  assign vram_req  = in_window && rd_valid && !scan.x[2];

  // pattern bytes hold the leftmost pixel in bit 7
  assign byte_ordered = rd_entry.h_flip ? vram_rdata : rev8(vram_rdata);

  ////////////////////////////////////////////////////////////
  // plane capture, last clock of each read sub-phase
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in)
  begin
    if (vram_req && scan.pix_pulse && scan.x[0])
    begin
      if (sub_phase == 2'd0)
        plane0_q <= byte_ordered;
      else
        plane1_q <= byte_ordered;
    end
  end

  assign slot_wr  = in_window && scan.pix_pulse && (scan.x[2:0] == 3'b100);
  assign slot_idx = rd_idx;

  always_comb
  begin
    slot_data = '0;         // unused slots stay transparent
    if (rd_valid)
    begin
      slot_data.primary = rd_entry.primary;
      slot_data.prio    = rd_entry.prio;
      slot_data.palette = rd_entry.palette;
      slot_data.plane1  = plane1_q;
      slot_data.plane0  = plane0_q;
      slot_data.x       = rd_entry.x;
    end
  end

  // the line buffer entry must not move while a plane is being read
  a_addr_held : assert property (
    @(posedge clk_in) disable iff (rst_in)
      vram_req && !scan.pix_pulse |=> $stable(vram_addr)
  ) else $error("vram address changed inside a read column");

endmodule

// ==== src/spr_pixel_mux.sv ====
// eight slot shifters with first-opaque select; slot x is matched against the full screen x
`timescale 1ns/1ps

module spr_pixel_mux
(
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           en,
  input  spr_pkg::scan_t scan,
  input  logic           slot_wr,
  input  logic [2:0]     slot_idx,
  input  spr_pkg::slot_t slot_data,
  output spr_pkg::pixel_t pixel
);

  spr_pkg::slot_t slot_mem [spr_pkg::SPR_PER_LINE];

  logic [7:0]                      plane0_sh [spr_pkg::SPR_PER_LINE];
  logic [7:0]                      plane1_sh [spr_pkg::SPR_PER_LINE];
  logic [spr_pkg::SPR_PER_LINE-1:0] opaque;
  logic                            scan_vis;

  assign scan_vis = en && (scan.y < spr_pkg::VISIBLE_LINES);

  // written during the previous line's fetch window
  always_ff @(posedge clk_in)
  begin
    if (slot_wr)
      slot_mem[slot_idx] <= slot_data;
  end

  ////////////////////////////////////////////////////////////
  // per slot plane shifters
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < spr_pkg::SPR_PER_LINE; i++)
  begin : g_slot
    always_ff @(posedge clk_in)
    begin
      if (rst_in)
      begin
        plane0_sh[i] <= '0;
        plane1_sh[i] <= '0;
      end
      else if (scan_vis)
      begin
        if (scan.pix_pulse)
        begin
          plane0_sh[i] <= {1'b0, plane0_sh[i][7:1]};
          plane1_sh[i] <= {1'b0, plane1_sh[i][7:1]};
        end
        else if (scan.x == {2'b00, slot_mem[i].x})
        begin
          plane0_sh[i] <= slot_mem[i].plane0;   // object starts on this column
          plane1_sh[i] <= slot_mem[i].plane1;
        end
      end
    end

    assign opaque[i] = plane1_sh[i][0] | plane0_sh[i][0];
  end

  // lowest slot wins, so scan from the top down
  always_comb
  begin
    pixel = '0;
    for (int i = spr_pkg::SPR_PER_LINE - 1; i >= 0; i--)
    begin
      if (opaque[i])
      begin
        pixel.primary = slot_mem[i].primary;
        pixel.prio    = slot_mem[i].prio;
        pixel.index   = {slot_mem[i].palette, plane1_sh[i][0], plane0_sh[i][0]};
      end
    end
  end

endmodule

// ==== src/spr_top.sv ====
// sprite unit top; screen timing and vram come from outside, vram data expected same clock
`timescale 1ns/1ps

module spr_top
(
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            en,
  input  logic            pt_sel,
  input  spr_pkg::scan_t  scan,
  input  logic [7:0]      oam_addr,
  input  logic [7:0]      oam_wdata,
  input  logic            oam_wr,
  input  logic [7:0]      vram_rdata,
  output logic [7:0]      oam_rdata,
  output logic            overflow,
  output spr_pkg::pixel_t pixel,
  output logic [13:0]     vram_addr,
  output logic            vram_req
);

  logic                 full;
  logic                 push;
  spr_pkg::line_entry_t push_entry;
  logic [2:0]           rd_idx;
  spr_pkg::line_entry_t rd_entry;
  logic                 rd_valid;
  logic                 slot_wr;
  logic [2:0]           slot_idx;
  spr_pkg::slot_t       slot_data;

  spr_eval u_eval
  (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .en         (en),
    .scan       (scan),
    .oam_addr   (oam_addr),
    .oam_wdata  (oam_wdata),
    .oam_wr     (oam_wr),
    .full       (full),
    .oam_rdata  (oam_rdata),
    .push       (push),
    .push_entry (push_entry),
    .overflow   (overflow)
  );

  spr_line_buf u_line_buf
  (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .scan       (scan),
    .push       (push),
    .push_entry (push_entry),
    .rd_idx     (rd_idx),
    .full       (full),
    .rd_entry   (rd_entry),
    .rd_valid   (rd_valid)
  );

  spr_fetch u_fetch
  (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .en         (en),
    .pt_sel     (pt_sel),
    .scan       (scan),
    .rd_entry   (rd_entry),
    .rd_valid   (rd_valid),
    .vram_rdata (vram_rdata),
    .rd_idx     (rd_idx),
    .vram_addr  (vram_addr),
    .vram_req   (vram_req),
    .slot_wr    (slot_wr),
    .slot_idx   (slot_idx),
    .slot_data  (slot_data)
  );

  spr_pixel_mux u_pixel_mux
  (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .en         (en),
    .scan       (scan),
    .slot_wr    (slot_wr),
    .slot_idx   (slot_idx),
    .slot_data  (slot_data),
    .pixel      (pixel)
  );

endmodule

// ==== sim/tb_spr.sv ====
// directed testbench for spr_top; runs whole frames at 4 clocks per pixel, so it takes a while
`timescale 1ns/1ps

module tb_spr;

  localparam int     LINES      = 262;
  localparam int     COLS       = 341;
  localparam int     NUM_FRAMES = 6;     // frames used by all tests together
  localparam longint FRAME_NS   = longint'(LINES) * COLS * 4 * 100;
  localparam int     OBJ_COUNT  = spr_pkg::OAM_BYTES / 4;
  localparam int     OVF_LINE   = 20;
  localparam int     LAST_EVAL  = 4 * (spr_pkg::SPR_PER_LINE - 1);  // column of the 8th object

  localparam int MODE_IDLE   = 0;
  localparam int MODE_NO_OVF = 1;
  localparam int MODE_OVF    = 2;
  localparam int MODE_FETCH  = 3;
  localparam int MODE_PIXEL  = 4;

  logic            clk_in;
  logic            rst_in;
  logic            en;
  logic            pt_sel;
  spr_pkg::scan_t  scan;
  logic [7:0]      oam_addr;
  logic [7:0]      oam_wdata;
  logic            oam_wr;
  logic [7:0]      vram_rdata;
  logic [7:0]      oam_rdata;
  logic            overflow;
  spr_pkg::pixel_t pixel;
  logic [13:0]     vram_addr;
  logic            vram_req;

  logic [7:0] oam_shadow [spr_pkg::OAM_BYTES];  // byte 0 y, 1 tile, 2 attr, 3 x
  int         mode;
  int         seed;

  spr_top u_dut
  (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .en         (en),
    .pt_sel     (pt_sel),
    .scan       (scan),
    .oam_addr   (oam_addr),
    .oam_wdata  (oam_wdata),
    .oam_wr     (oam_wr),
    .vram_rdata (vram_rdata),
    .oam_rdata  (oam_rdata),
    .overflow   (overflow),
    .pixel      (pixel),
    .vram_addr  (vram_addr),
    .vram_req   (vram_req)
  );

  assign vram_rdata = vram_addr[7:0] ^ 8'h5A;  // pattern memory answers in the same clock

  initial
  begin
    clk_in = 1'b0;
  end

  always #50 clk_in = ~clk_in;

  ////////////////////////////////////////////////////////////
  // reference model, built on the OAM shadow copy
  ////////////////////////////////////////////////////////////
  function automatic logic covers_line(input int obj, input int line);
    int top;
    top = oam_shadow[4 * obj] + 1;   // y byte holds the top row minus one
    return (line < spr_pkg::VISIBLE_LINES) && (line >= top) && (line < top + 8);
  endfunction

  function automatic logic [3:0] obj_row(input int obj, input int line);
    int r;
    r = line - (oam_shadow[4 * obj] + 1);
    if (oam_shadow[4 * obj + 2][7])
      r = 7 - r;                     // v flip
    return 4'(r);
  endfunction

  function automatic logic [7:0] pattern_byte(input logic [7:0] tile, input logic plane,
                                              input logic [3:0] row);
    logic [13:0] addr;
    addr = {pt_sel, tile, plane, row};
    return addr[7:0] ^ 8'h5A;
  endfunction

  // nth in-range object of a line in OAM order, -1 when the line has fewer
  function automatic int find_slot_obj(input int line, input int slot);
    int n;
    n = 0;
    for (int i = 0; i < OBJ_COUNT; i++)
    begin
      if (covers_line(i, line))
      begin
        if (n == slot)
          return i;
        n++;
      end
    end
    return -1;
  endfunction

  function automatic spr_pkg::pixel_t expected_pixel(input int line, input int col);
    spr_pkg::pixel_t p;
    int              n;
    int              k;
    int              bit_pos;
    logic [7:0]      attr;
    logic [7:0]      b0;
    logic [7:0]      b1;
    p = '0;
    n = 0;
    for (int i = 0; (i < OBJ_COUNT) && (n < spr_pkg::SPR_PER_LINE); i++)
    begin
      if (covers_line(i, line))
      begin
        n++;
        k = col - oam_shadow[4 * i + 3];
        if ((k >= 0) && (k < 8))
        begin
          attr    = oam_shadow[4 * i + 2];
          b0      = pattern_byte(oam_shadow[4 * i + 1], 1'b0, obj_row(i, line));
          b1      = pattern_byte(oam_shadow[4 * i + 1], 1'b1, obj_row(i, line));
          bit_pos = attr[6] ? k : 7 - k;   // unflipped pattern keeps the left pixel in bit 7
          if (b0[bit_pos] || b1[bit_pos])
          begin
            p.primary = (i == 0);
            p.prio    = attr[5];
            p.index   = {attr[1:0], b1[bit_pos], b0[bit_pos]};
            return p;
          end
        end
      end
    end
    return p;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////////////////////////
  // per cycle comparison, sampled just before the rising edge
  ////////////////////////////////////////////////////////////
  task automatic compare_fetch(input int x, input int yn);
    int          obj;
    int          phase;
    logic        exp_req;
    logic [13:0] exp_addr;
    exp_req  = 1'b0;
    exp_addr = '0;
    if ((yn < spr_pkg::VISIBLE_LINES) && (x >= spr_pkg::FETCH_START)
        && (x < spr_pkg::FETCH_END))
    begin
      obj   = find_slot_obj(yn, (x - spr_pkg::FETCH_START) / 8);
      phase = ((x - spr_pkg::FETCH_START) % 8) / 2;   // 0 plane 0, 1 plane 1, 2 slot write
      if ((obj >= 0) && (phase < 2))
      begin
        exp_req  = 1'b1;
        exp_addr = {pt_sel, oam_shadow[4 * obj + 1], phase[0], obj_row(obj, yn)};
      end
    end
    assert (vram_req == exp_req)
      else report_mismatch("vram_req", exp_req, vram_req);
    if (exp_req)
      assert (vram_addr == exp_addr)
        else report_mismatch("vram_addr", exp_addr, vram_addr);
  endtask

  task automatic sample_outputs();
    int              x;
    int              y;
    spr_pkg::pixel_t exp_pix;
    x = scan.x;
    y = scan.y;
    if (mode == MODE_NO_OVF)
      assert (overflow == 1'b0) else report_mismatch("overflow", 0, overflow);
    else if (mode == MODE_OVF)
    begin
      // clear from the frame start clock, set a clock after the 8th push
      if ((y < OVF_LINE - 1) || ((y == OVF_LINE - 1) && (x <= LAST_EVAL))
          || ((y == LINES - 1) && (x >= 1)))
        assert (overflow == 1'b0) else report_mismatch("overflow", 0, overflow);
      else if ((y < LINES - 1) && ((y > OVF_LINE - 1) || (x >= LAST_EVAL + 2)))
        assert (overflow == 1'b1) else report_mismatch("overflow", 1, overflow);
    end
    else if (mode == MODE_FETCH)
      compare_fetch(x, scan.y_next);
    else if ((mode == MODE_PIXEL) && scan.pix_pulse && (y < spr_pkg::VISIBLE_LINES)
             && (x < spr_pkg::FETCH_START))
    begin
      exp_pix = expected_pixel(y, x);
      assert (pixel == exp_pix) else report_mismatch("pixel", exp_pix, pixel);
    end
  endtask

  // one frame of screen timing, 4 clocks per pixel with the pulse on the last
  task automatic run_frame();
    for (int y = 0; y < LINES; y++)
    begin
      for (int x = 0; x < COLS; x++)
      begin
        for (int c = 0; c < 4; c++)
        begin
          @(negedge clk_in);
          scan.x         = spr_pkg::coord_t'(x);
          scan.y         = spr_pkg::coord_t'(y);
          scan.y_next    = spr_pkg::coord_t'((y == LINES - 1) ? 0 : y + 1);
          scan.pix_pulse = (c == 3);
          #40;
          sample_outputs();
        end
      end
    end
    @(negedge clk_in);
    scan.pix_pulse = 1'b0;
  endtask

  task automatic write_oam(input logic [7:0] addr, input logic [7:0] data);
    @(negedge clk_in);
    oam_addr  = addr;
    oam_wdata = data;
    oam_wr    = 1'b1;
    @(negedge clk_in);
    oam_wr           = 1'b0;
    oam_shadow[addr] = data;
  endtask

  task automatic place_object(input int idx, input logic [7:0] y, input logic [7:0] tile,
                              input logic [7:0] attr, input logic [7:0] x);
    write_oam(8'(4 * idx), y);
    write_oam(8'(4 * idx + 1), tile);
    write_oam(8'(4 * idx + 2), attr);   // palette [1:0], priority 5, h flip 6, v flip 7
    write_oam(8'(4 * idx + 3), x);
  endtask

  task automatic clear_oam();
    for (int a = 0; a < spr_pkg::OAM_BYTES; a++)
      write_oam(8'(a), 8'hFF);          // y of 255 keeps every object off screen
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic oam_readback();
    for (int a = 0; a < spr_pkg::OAM_BYTES; a++)
      write_oam(8'(a), 8'($random(seed)));
    for (int a = 0; a < spr_pkg::OAM_BYTES; a++)
    begin
      @(negedge clk_in);
      oam_addr = 8'(a);
      #40;
      assert (oam_rdata == oam_shadow[a])
        else report_mismatch("oam_rdata", oam_shadow[a], oam_rdata);
    end
  endtask

  task automatic overflow_by_count();
    clear_oam();
    for (int i = 0; i < spr_pkg::SPR_PER_LINE - 1; i++)
      place_object(i, 8'(OVF_LINE - 1), 8'(8'h10 + i), 8'h00, 8'(16 * i));
    mode = MODE_NO_OVF;
    run_frame();
    place_object(spr_pkg::SPR_PER_LINE - 1, 8'(OVF_LINE - 1), 8'h20, 8'h00, 8'd200);
    mode = MODE_OVF;
    run_frame();
  endtask

  task automatic fetch_addressing();
    clear_oam();
    pt_sel = 1'b0;
    place_object(5, 8'd49, 8'hA7, 8'h02, 8'd60);   // lines 50 to 57
    mode = MODE_FETCH;
    run_frame();
    pt_sel = 1'b1;
    place_object(5, 8'd49, 8'hA7, 8'h82, 8'd60);   // same object, v flip
    run_frame();
  endtask

  task automatic pixel_plain();
    clear_oam();
    pt_sel = 1'b0;
    place_object(3, 8'd30, 8'h3C, 8'h22, 8'd40);   // palette 2, behind playfield
    mode = MODE_PIXEL;
    run_frame();
  endtask

  task automatic flip_and_priority();
    clear_oam();
    pt_sel = 1'b1;
    place_object(0, 8'd60, 8'h11, 8'h41, 8'd100);  // h flip, primary
    place_object(1, 8'd60, 8'h06, 8'h23, 8'd104);  // overlaps columns 104 to 107
    mode = MODE_PIXEL;
    run_frame();
  endtask

  initial
  begin
    seed      = 1303;
    mode      = MODE_IDLE;
    rst_in    = 1'b1;
    en        = 1'b0;
    pt_sel    = 1'b0;
    scan      = '0;
    oam_addr  = '0;
    oam_wdata = '0;
    oam_wr    = 1'b0;
    repeat (10) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    en     = 1'b1;
    oam_readback();
    overflow_by_count();
    fetch_addressing();
    pixel_plain();
    flip_and_priority();
    $display("PASS: all tests");
    $finish;
  end

  // one frame of margin on top of the frames the tests run
  initial
  begin
    #((NUM_FRAMES + 1) * FRAME_NS);
    $display("watchdog expired, the tests did not finish in %0d frame times", NUM_FRAMES + 1);
    $display("FAIL: see errors above");
    $fatal(1, "simulation timed out");
  end

endmodule

// ==== spr.f ====
src/spr_pkg.sv
src/spr_eval.sv
src/spr_line_buf.sv
src/spr_fetch.sv
src/spr_pixel_mux.sv
src/spr_top.sv
sim/tb_spr.sv
